// ==== logic/rv32_types_pkg.sv ====
`default_nettype none

package rv32_types_pkg;

  typedef logic [31:0] word_t;    // data / address word
  typedef logic [6:0]  opcode_t;  // insn[6:0]
  typedef logic [2:0]  funct3_t;  // insn[14:12]
  typedef logic [2:0]  kind_t;    // decoded instruction class

  localparam opcode_t OPC_BRANCH = 7'b1100011;  // conditional branches
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;  // signed
  localparam funct3_t F3_BGE  = 3'b101;  // signed
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam kind_t KIND_BRANCH  = 3'd0;
  localparam kind_t KIND_JAL     = 3'd1;
  localparam kind_t KIND_JALR    = 3'd2;
  localparam kind_t KIND_LUI     = 3'd3;
  localparam kind_t KIND_AUIPC   = 3'd4;
  localparam kind_t KIND_ILLEGAL = 3'd5;  // bad opcode or branch funct3

endpackage

`default_nettype wire

// ==== logic/commit_apb_pkg.sv ====
`default_nettype none

package commit_apb_pkg;

  typedef logic [7:0] apb_addr_t;  // byte offset into the register map

  // host-loaded issue record
  localparam apb_addr_t REG_PC      = 8'h00;
  localparam apb_addr_t REG_INSN    = 8'h04;
  localparam apb_addr_t REG_RS1     = 8'h08;
  localparam apb_addr_t REG_RS2     = 8'h0C;
  localparam apb_addr_t REG_ISSUE   = 8'h10;  // wo, bit 0 = predicted taken

  // commit side read-back
  localparam apb_addr_t REG_STATUS  = 8'h14;  // sticky, w1c
  localparam apb_addr_t REG_LAST_PC = 8'h18;
  localparam apb_addr_t REG_BADADDR = 8'h1C;
  localparam apb_addr_t REG_RESULT  = 8'h20;

  localparam int ST_MAL_BIT     = 0;  // misaligned target seen
  localparam int ST_ILLEGAL_BIT = 1;  // illegal insn seen

endpackage

`default_nettype wire

// ==== logic/decode_execute_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_execute_if;

  logic                    valid;    // record present in execute input
  rv32_types_pkg::kind_t   kind;
  rv32_types_pkg::funct3_t funct3;   // branch condition select
  rv32_types_pkg::word_t   pc;
  rv32_types_pkg::word_t   imm;      // already sign extended
  rv32_types_pkg::word_t   rs1_val;
  rv32_types_pkg::word_t   rs2_val;
  logic                    pred;     // predicted taken from host

  modport decode (output valid, kind, funct3, pc, imm, rs1_val, rs2_val, pred);

  modport execute (input valid, kind, funct3, pc, imm, rs1_val, rs2_val, pred);

endinterface

`default_nettype wire

// ==== logic/execute_commit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface execute_commit_if;

  logic                  valid;   // resolved record present
  rv32_types_pkg::kind_t kind;
  rv32_types_pkg::word_t pc;
  rv32_types_pkg::word_t target;  // next pc after this insn
  logic                  taken;   // branch outcome, 0 for non-branches
  rv32_types_pkg::word_t result;  // rd write value
  logic                  pred;

  modport execute (output valid, kind, pc, target, taken, result, pred);

  modport commit (input valid, kind, pc, target, taken, result, pred);

endinterface

`default_nettype wire

// ==== logic/apb_issue_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_issue_regs (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      PSEL,
  input  logic                      PENABLE,
  input  logic                      PWRITE,
  input  commit_apb_pkg::apb_addr_t PADDR,
  input  rv32_types_pkg::word_t     PWDATA,
  output rv32_types_pkg::word_t     PRDATA,
  output logic                      issue_valid,
  output rv32_types_pkg::word_t     pc,
  output rv32_types_pkg::word_t     insn,
  output rv32_types_pkg::word_t     rs1_val,
  output rv32_types_pkg::word_t     rs2_val,
  output logic                      issue_pred,
  input  logic                      status_mal,
  input  logic                      status_illegal,
  input  rv32_types_pkg::word_t     last_pc,
  input  rv32_types_pkg::word_t     badaddr_q,
  input  rv32_types_pkg::word_t     result_q,
  output logic                      clr_mal,
  output logic                      clr_illegal
);

  logic                  wr_access;  // write in access phase
  rv32_types_pkg::word_t status_w;   // packed sticky flags

  assign wr_access = PSEL & PENABLE & PWRITE;

  // issue strobe lives only for the access cycle, decode samples on that edge
  assign issue_valid = wr_access & (PADDR == commit_apb_pkg::REG_ISSUE);
  assign issue_pred  = PWDATA[0];

  // w1c strobes for the sticky status
  assign clr_mal     = wr_access & (PADDR == commit_apb_pkg::REG_STATUS) &
                       PWDATA[commit_apb_pkg::ST_MAL_BIT];
  assign clr_illegal = wr_access & (PADDR == commit_apb_pkg::REG_STATUS) &
                       PWDATA[commit_apb_pkg::ST_ILLEGAL_BIT];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc      <= '0;
      insn    <= '0;
      rs1_val <= '0;
      rs2_val <= '0;
    end else if (wr_access) begin
      case (PADDR)
        commit_apb_pkg::REG_PC:   pc      <= PWDATA;
        commit_apb_pkg::REG_INSN: insn    <= PWDATA;
        commit_apb_pkg::REG_RS1:  rs1_val <= PWDATA;
        commit_apb_pkg::REG_RS2:  rs2_val <= PWDATA;
        default: ;  // issue/status handled by strobes
      endcase
    end
  end

  always_comb begin
    status_w                                 = '0;
    status_w[commit_apb_pkg::ST_MAL_BIT]     = status_mal;
    status_w[commit_apb_pkg::ST_ILLEGAL_BIT] = status_illegal;
  end

  // read mux, no wait states
  always_comb begin
    case (PADDR)
      commit_apb_pkg::REG_PC:      PRDATA = pc;
      commit_apb_pkg::REG_INSN:    PRDATA = insn;
      commit_apb_pkg::REG_RS1:     PRDATA = rs1_val;
      commit_apb_pkg::REG_RS2:     PRDATA = rs2_val;
      commit_apb_pkg::REG_STATUS:  PRDATA = status_w;
      commit_apb_pkg::REG_LAST_PC: PRDATA = last_pc;
      commit_apb_pkg::REG_BADADDR: PRDATA = badaddr_q;
      commit_apb_pkg::REG_RESULT:  PRDATA = result_q;
      default:                     PRDATA = '0;  // unmapped and issue read 0
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/insn_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  issue_valid,
  input  rv32_types_pkg::word_t pc,
  input  rv32_types_pkg::word_t insn,
  input  rv32_types_pkg::word_t rs1_val,
  input  rv32_types_pkg::word_t rs2_val,
  input  logic                  issue_pred,
  decode_execute_if.decode      de
);

  rv32_types_pkg::opcode_t opcode;
  rv32_types_pkg::funct3_t funct3;
  rv32_types_pkg::kind_t   kind_d;
  rv32_types_pkg::word_t   imm_d;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  always_comb begin
    case (opcode)
      rv32_types_pkg::OPC_BRANCH: begin
        case (funct3)
          rv32_types_pkg::F3_BEQ, rv32_types_pkg::F3_BNE,
          rv32_types_pkg::F3_BLT, rv32_types_pkg::F3_BGE,
          rv32_types_pkg::F3_BLTU, rv32_types_pkg::F3_BGEU:
                   kind_d = rv32_types_pkg::KIND_BRANCH;
          default: kind_d = rv32_types_pkg::KIND_ILLEGAL;  // 010, 011
        endcase
      end
      rv32_types_pkg::OPC_JAL:   kind_d = rv32_types_pkg::KIND_JAL;
      rv32_types_pkg::OPC_JALR:  kind_d = rv32_types_pkg::KIND_JALR;
      rv32_types_pkg::OPC_LUI:   kind_d = rv32_types_pkg::KIND_LUI;
      rv32_types_pkg::OPC_AUIPC: kind_d = rv32_types_pkg::KIND_AUIPC;
      default:                   kind_d = rv32_types_pkg::KIND_ILLEGAL;
    endcase
  end

  // immediate format follows the kind
  always_comb begin
    case (kind_d)
      rv32_types_pkg::KIND_BRANCH:  // B-type
        imm_d = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      rv32_types_pkg::KIND_JAL:     // J-type
        imm_d = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      rv32_types_pkg::KIND_JALR:    // I-type
        imm_d = {{21{insn[31]}}, insn[30:20]};
      rv32_types_pkg::KIND_LUI, rv32_types_pkg::KIND_AUIPC:
        imm_d = {insn[31:12], 12'b0};  // U-type
      default: imm_d = '0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) de.valid <= 1'b0;
    else       de.valid <= issue_valid;
  end

  always_ff @(posedge CLK) begin
    if (issue_valid) begin
      de.kind    <= kind_d;
      de.funct3  <= funct3;
      de.pc      <= pc;
      de.imm     <= imm_d;
      de.rs1_val <= rs1_val;
      de.rs2_val <= rs2_val;
      de.pred    <= issue_pred;
    end
  end

endmodule

`default_nettype wire

// ==== logic/branch_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_execute (
  input  logic              CLK,
  input  logic              nRST,
  decode_execute_if.execute de,
  execute_commit_if.execute ec
);

  logic                  cond;      // raw compare outcome
  logic                  taken_d;
  rv32_types_pkg::word_t pc_imm;    // pc relative sum
  rv32_types_pkg::word_t pc_4;      // fall through / link
  rv32_types_pkg::word_t target_d;
  rv32_types_pkg::word_t result_d;

  assign pc_imm = de.pc + de.imm;
  assign pc_4   = de.pc + 32'd4;

  always_comb begin
    case (de.funct3)
      rv32_types_pkg::F3_BEQ:  cond = (de.rs1_val == de.rs2_val);
      rv32_types_pkg::F3_BNE:  cond = (de.rs1_val != de.rs2_val);
      rv32_types_pkg::F3_BLT:  cond = ($signed(de.rs1_val) <  $signed(de.rs2_val));
      rv32_types_pkg::F3_BGE:  cond = ($signed(de.rs1_val) >= $signed(de.rs2_val));
      rv32_types_pkg::F3_BLTU: cond = (de.rs1_val <  de.rs2_val);
      rv32_types_pkg::F3_BGEU: cond = (de.rs1_val >= de.rs2_val);
      default:                 cond = 1'b0;
    endcase
  end

  assign taken_d = (de.kind == rv32_types_pkg::KIND_BRANCH) & cond;  // branches only

  always_comb begin
    target_d = pc_4;
    result_d = '0;  // branches write nothing
    case (de.kind)
      rv32_types_pkg::KIND_BRANCH: target_d = taken_d ? pc_imm : pc_4;
      rv32_types_pkg::KIND_JAL: begin
        target_d = pc_imm;
        result_d = pc_4;  // link
      end
      rv32_types_pkg::KIND_JALR: begin
        target_d = (de.rs1_val + de.imm) & ~32'd1;  // bit 0 dropped
        result_d = pc_4;
      end
      rv32_types_pkg::KIND_LUI:   result_d = de.imm;
      rv32_types_pkg::KIND_AUIPC: result_d = pc_imm;
      default: ;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) ec.valid <= 1'b0;
    else       ec.valid <= de.valid;
  end

  always_ff @(posedge CLK) begin
    if (de.valid) begin
      ec.kind   <= de.kind;
      ec.pc     <= de.pc;
      ec.target <= target_d;
      ec.taken  <= taken_d;
      ec.result <= result_d;
      ec.pred   <= de.pred;
    end
  end

endmodule

`default_nettype wire

// ==== logic/commit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  halt,
  execute_commit_if.commit      ec,
  input  logic                  clr_mal,
  input  logic                  clr_illegal,
  output logic                  commit_valid,
  output logic                  mal_insn,
  output logic                  illegal_insn,
  output rv32_types_pkg::word_t badaddr,
  output logic                  update_predictor,
  output logic                  prediction,
  output rv32_types_pkg::word_t update_addr,
  output logic                  branch_result,
  output logic                  status_mal,
  output logic                  status_illegal,
  output rv32_types_pkg::word_t last_pc,
  output rv32_types_pkg::word_t badaddr_q,
  output rv32_types_pkg::word_t result_q
);

  logic is_branch, is_jump;
  logic mal_d, illegal_d;
  logic good_d;  // commits without any fault

  assign is_branch = (ec.kind == rv32_types_pkg::KIND_BRANCH);
  assign is_jump   = (ec.kind == rv32_types_pkg::KIND_JAL) |
                     (ec.kind == rv32_types_pkg::KIND_JALR);
  assign illegal_d = ec.valid & (ec.kind == rv32_types_pkg::KIND_ILLEGAL);
  // redirect to a non word aligned pc
  assign mal_d     = ec.valid & (is_jump | (is_branch & ec.taken)) & (ec.target[1:0] != 2'b00);
  assign good_d    = ec.valid & ~mal_d & ~illegal_d;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      commit_valid     <= 1'b0;
      mal_insn         <= 1'b0;
      illegal_insn     <= 1'b0;
      update_predictor <= 1'b0;
      status_mal       <= 1'b0;
      status_illegal   <= 1'b0;
      last_pc          <= '0;
      badaddr_q        <= '0;
      result_q         <= '0;
    end else begin
      commit_valid     <= ec.valid;
      mal_insn         <= mal_d;
      illegal_insn     <= illegal_d;
      update_predictor <= ec.valid & is_branch;
      status_mal       <= mal_d | (status_mal & ~clr_mal);  // set wins over clear
      status_illegal   <= illegal_d | (status_illegal & ~clr_illegal);
      if (halt)        last_pc <= '0;
      else if (good_d) last_pc <= ec.pc;
      if (mal_d | illegal_d) badaddr_q <= ec.pc;  // faulting pc held for host
      if (good_d)            result_q  <= ec.result;
    end
  end

  // per commit payload, qualified by the pulses above
  always_ff @(posedge CLK) begin
    if (ec.valid) begin
      badaddr       <= ec.pc;
      prediction    <= ec.pred;
      update_addr   <= ec.target;
      branch_result <= ec.taken;
    end
  end

endmodule

`default_nettype wire

// ==== logic/branch_commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_commit_top (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      PSEL,
  input  logic                      PENABLE,
  input  logic                      PWRITE,
  input  commit_apb_pkg::apb_addr_t PADDR,
  input  rv32_types_pkg::word_t     PWDATA,
  output rv32_types_pkg::word_t     PRDATA,
  output logic                      PREADY,
  output logic                      PSLVERR,
  input  logic                      halt,
  output logic                      commit_valid,
  output logic                      mal_insn,
  output logic                      illegal_insn,
  output rv32_types_pkg::word_t     badaddr,
  output logic                      update_predictor,
  output logic                      prediction,
  output rv32_types_pkg::word_t     update_addr,
  output logic                      branch_result
);

  logic                  issue_valid, issue_pred;
  rv32_types_pkg::word_t pc, insn, rs1_val, rs2_val;  // issue record
  logic                  status_mal, status_illegal, clr_mal, clr_illegal;
  rv32_types_pkg::word_t last_pc, badaddr_q, result_q;  // read-back

  assign PREADY  = 1'b1;  // zero wait states
  assign PSLVERR = 1'b0;

  decode_execute_if u_de_if ();
  execute_commit_if u_ec_if ();

  apb_issue_regs u_apb_issue_regs (
    .CLK, .nRST, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA,
    .issue_valid, .pc, .insn, .rs1_val, .rs2_val, .issue_pred,
    .status_mal, .status_illegal, .last_pc, .badaddr_q, .result_q,
    .clr_mal, .clr_illegal
  );

  insn_decode u_insn_decode (
    .CLK, .nRST, .issue_valid, .pc, .insn, .rs1_val, .rs2_val, .issue_pred,
    .de (u_de_if.decode)
  );

  branch_execute u_branch_execute (.CLK, .nRST, .de(u_de_if.execute), .ec(u_ec_if.execute));

  commit_stage u_commit_stage (
    .CLK, .nRST, .halt, .ec(u_ec_if.commit), .clr_mal, .clr_illegal,
    .commit_valid, .mal_insn, .illegal_insn, .badaddr,
    .update_predictor, .prediction, .update_addr, .branch_result,
    .status_mal, .status_illegal, .last_pc, .badaddr_q, .result_q
  );

endmodule

`default_nettype wire

// ==== verif/branch_commit_tests.svh ====
  // B-type with x1/x2 as sources
  function automatic rv32_types_pkg::word_t branch_word(input logic [12:0] imm,
                                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv32_types_pkg::word_t jal_word(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'h6F};
  endfunction

  function automatic rv32_types_pkg::word_t jalr_word(input logic [11:0] imm);
    return {imm, 5'd1, 3'b000, 5'd1, 7'h67};
  endfunction

  function automatic rv32_types_pkg::word_t upper_word(input logic [19:0] imm,
                                                       input logic [6:0] opc);
    return {imm, 5'd1, opc};  // lui or auipc
  endfunction

  task automatic regs_readback();
    commit_apb_pkg::apb_addr_t addrs [4];
    rv32_types_pkg::word_t     vals [4];
    addrs = '{commit_apb_pkg::REG_PC, commit_apb_pkg::REG_INSN,
              commit_apb_pkg::REG_RS1, commit_apb_pkg::REG_RS2};
    for (int i = 0; i < 4; i++) begin
      vals[i] = $random(seed);
      apb_write(addrs[i], vals[i]);
    end
    for (int i = 0; i < 4; i++) read_and_compare(addrs[i], vals[i], $sformatf("reg %h", addrs[i]));
    read_and_compare(8'h3C, 32'h0, "unmapped reg 3c");  // hole in the map
  endtask

  task automatic branch_resolution();
    logic [2:0]            f3s [6];
    rv32_types_pkg::word_t res;
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int i = 0; i < 6; i++) begin
      issue_insn(32'h2000, branch_word(13'h0010, f3s[i]), $random(seed), $random(seed), i[0], res);
      issue_insn(32'h2100, branch_word(13'h1FF0, f3s[i]), 32'h55, 32'h55, ~i[0], res);  // equal
      issue_insn(32'h2200, branch_word(13'h0020, f3s[i]), 32'h5, 32'h7, i[0], res);
      // negative vs positive splits signed and unsigned compares
      issue_insn(32'h2300, branch_word(13'h0040, f3s[i]), 32'hFFFF_FFF0, 32'h10, 1'b1, res);
      issue_insn(32'h2400, branch_word(13'h0040, f3s[i]), 32'h10, 32'hFFFF_FFF0, 1'b0, res);
    end
  endtask

  task automatic jumps_and_upper();
    rv32_types_pkg::word_t res;
    issue_insn(32'h3000, jal_word(21'h000100), $random(seed), $random(seed), 1'b0, res);
    read_and_compare(commit_apb_pkg::REG_RESULT, res, "REG_RESULT jal");
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h3000, "REG_LAST_PC jal");
    issue_insn(32'h3100, jalr_word(12'h008), 32'h4001, $random(seed), 1'b0, res);  // bit 0 dropped
    read_and_compare(commit_apb_pkg::REG_RESULT, res, "REG_RESULT jalr");
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h3100, "REG_LAST_PC jalr");
    issue_insn(32'h3200, upper_word(20'hABCDE, 7'h37), $random(seed), 32'h0, 1'b0, res);
    read_and_compare(commit_apb_pkg::REG_RESULT, res, "REG_RESULT lui");
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h3200, "REG_LAST_PC lui");
    issue_insn(32'h3300, upper_word(20'h00012, 7'h17), $random(seed), 32'h0, 1'b1, res);
    read_and_compare(commit_apb_pkg::REG_RESULT, res, "REG_RESULT auipc");
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h3300, "REG_LAST_PC auipc");
  endtask

  task automatic misaligned_target();
    rv32_types_pkg::word_t res;
    rv32_types_pkg::word_t mal_bit;
    mal_bit = 32'd1 << commit_apb_pkg::ST_MAL_BIT;
    issue_insn(32'h5000, upper_word(20'h00001, 7'h37), 32'h0, 32'h0, 1'b0, res);
    issue_insn(32'h5004, jalr_word(12'h002), 32'h6000, 32'h0, 1'b0, res);  // lands on 6002
    read_and_compare(commit_apb_pkg::REG_STATUS, mal_bit, "REG_STATUS after jalr");
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h5000, "REG_LAST_PC after jalr");
    read_and_compare(commit_apb_pkg::REG_BADADDR, 32'h5004, "REG_BADADDR after jalr");
    apb_write(commit_apb_pkg::REG_STATUS, mal_bit);  // w1c
    read_and_compare(commit_apb_pkg::REG_STATUS, 32'h0, "REG_STATUS cleared");
    issue_insn(32'h5008, branch_word(13'h0006, 3'b000), 32'h7, 32'h7, 1'b1, res);  // pc+6
    read_and_compare(commit_apb_pkg::REG_STATUS, mal_bit, "REG_STATUS after beq");
    read_and_compare(commit_apb_pkg::REG_BADADDR, 32'h5008, "REG_BADADDR after beq");
    apb_write(commit_apb_pkg::REG_STATUS, mal_bit);
  endtask

  task automatic illegal_opcode_sticky();
    rv32_types_pkg::word_t res;
    rv32_types_pkg::word_t ill_bit;
    ill_bit = 32'd1 << commit_apb_pkg::ST_ILLEGAL_BIT;
    issue_insn(32'h7000, 32'h0020_80B3, 32'h1, 32'h2, 1'b0, res);  // add x1, R-type
    read_and_compare(commit_apb_pkg::REG_STATUS, ill_bit, "REG_STATUS after add");
    read_and_compare(commit_apb_pkg::REG_BADADDR, 32'h7000, "REG_BADADDR after add");
    issue_insn(32'h7004, upper_word(20'h00005, 7'h37), 32'h0, 32'h0, 1'b0, res);
    read_and_compare(commit_apb_pkg::REG_STATUS, ill_bit, "REG_STATUS held");  // sticky
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h7004, "REG_LAST_PC after lui");
    apb_write(commit_apb_pkg::REG_STATUS, ill_bit);
    read_and_compare(commit_apb_pkg::REG_STATUS, 32'h0, "REG_STATUS cleared");
    issue_insn(32'h7008, branch_word(13'h0008, 3'b010), 32'h3, 32'h3, 1'b1, res);
    read_and_compare(commit_apb_pkg::REG_STATUS, ill_bit, "REG_STATUS after f3 010");
    apb_write(commit_apb_pkg::REG_STATUS, ill_bit);
  endtask

  task automatic halt_clears_last_pc();
    rv32_types_pkg::word_t res;
    issue_insn(32'h8000, upper_word(20'h00042, 7'h17), 32'h0, 32'h0, 1'b0, res);
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h8000, "REG_LAST_PC before halt");
    @(negedge CLK);
    halt = 1'b1;  // one cycle
    @(negedge CLK);
    halt = 1'b0;
    read_and_compare(commit_apb_pkg::REG_LAST_PC, 32'h0, "REG_LAST_PC after halt");
  endtask

// ==== verif/branch_commit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_commit_tb;

  logic                      CLK = 1'b0;
  logic                      nRST;
  logic                      PSEL, PENABLE, PWRITE;
  commit_apb_pkg::apb_addr_t PADDR;
  rv32_types_pkg::word_t     PWDATA, PRDATA;
  logic                      PREADY, PSLVERR;
  logic                      halt;
  logic                      commit_valid, mal_insn, illegal_insn;
  rv32_types_pkg::word_t     badaddr, update_addr;
  logic                      update_predictor, prediction, branch_result;

  int     errors = 0;
  int     checks = 0;
  integer seed   = 32'h0620_b839;  // operand stream

  branch_commit_top u_branch_commit_top (.*);

  always #50 CLK = ~CLK;  // 100 ns period

  task automatic compare_word(input string name, input rv32_types_pkg::word_t got,
                              input rv32_types_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // setup cycle then access cycle, idle afterwards
  task automatic apb_write(input commit_apb_pkg::apb_addr_t addr,
                           input rv32_types_pkg::word_t data);
    @(negedge CLK);
    PSEL   = 1'b1;
    PWRITE = 1'b1;
    PADDR  = addr;
    PWDATA = data;
    @(negedge CLK);
    PENABLE = 1'b1;
    @(negedge CLK);  // access edge has passed
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apb_read(input commit_apb_pkg::apb_addr_t addr,
                          output rv32_types_pkg::word_t data);
    @(negedge CLK);
    PSEL   = 1'b1;
    PWRITE = 1'b0;
    PADDR  = addr;
    @(negedge CLK);
    PENABLE = 1'b1;
    check_flag("PREADY", PREADY, 1'b1);    // no wait states expected
    check_flag("PSLVERR", PSLVERR, 1'b0);
    @(negedge CLK);
    data    = PRDATA;  // still driven, mid cycle
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic read_and_compare(input commit_apb_pkg::apb_addr_t addr,
                                  input rv32_types_pkg::word_t exp, input string name);
    rv32_types_pkg::word_t got;
    apb_read(addr, got);
    compare_word(name, got, exp);
  endtask

  // expected outcome straight from the RV32I encoding and the commit rules
  task automatic predict_outcome(input rv32_types_pkg::word_t pc, input rv32_types_pkg::word_t insn,
                                 input rv32_types_pkg::word_t rs1,
                                 input rv32_types_pkg::word_t rs2,
                                 output logic is_br, output logic tkn,
                                 output rv32_types_pkg::word_t tgt,
                                 output rv32_types_pkg::word_t res,
                                 output logic mal, output logic ill);
    logic [2:0]            f3;
    logic                  jmp;
    rv32_types_pkg::word_t imm_b, imm_j, imm_i, imm_u;
    f3    = insn[14:12];
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_u = {insn[31:12], 12'h000};
    is_br = 1'b0;
    tkn   = 1'b0;
    jmp   = 1'b0;
    ill   = 1'b0;
    tgt   = pc + 32'd4;  // fall through
    res   = '0;
    case (insn[6:0])
      7'h63: begin  // branch
        is_br = (f3 != 3'b010) && (f3 != 3'b011);
        ill   = !is_br;
        case (f3)
          3'b000:  tkn = (rs1 == rs2);
          3'b001:  tkn = (rs1 != rs2);
          3'b100:  tkn = ($signed(rs1) < $signed(rs2));
          3'b101:  tkn = ($signed(rs1) >= $signed(rs2));
          3'b110:  tkn = (rs1 < rs2);
          3'b111:  tkn = (rs1 >= rs2);
          default: tkn = 1'b0;
        endcase
        if (tkn) tgt = pc + imm_b;
      end
      7'h6F: begin  // jal
        jmp = 1'b1;
        tgt = pc + imm_j;
        res = pc + 32'd4;
      end
      7'h67: begin  // jalr
        jmp = 1'b1;
        tgt = (rs1 + imm_i) & 32'hFFFF_FFFE;
        res = pc + 32'd4;
      end
      7'h37:   res = imm_u;       // lui
      7'h17:   res = pc + imm_u;  // auipc
      default: ill = 1'b1;
    endcase
    mal = !ill && (jmp || tkn) && (tgt[1:0] != 2'b00);
  endtask

  // load the record, issue it, then check the one cycle commit pulse
  task automatic issue_insn(input rv32_types_pkg::word_t pc, input rv32_types_pkg::word_t insn,
                            input rv32_types_pkg::word_t rs1,
                            input rv32_types_pkg::word_t rs2,
                            input logic pred, output rv32_types_pkg::word_t exp_res);
    logic                  is_br, tkn, mal, ill;
    rv32_types_pkg::word_t tgt;
    int                    n;
    predict_outcome(pc, insn, rs1, rs2, is_br, tkn, tgt, exp_res, mal, ill);
    apb_write(commit_apb_pkg::REG_PC, pc);
    apb_write(commit_apb_pkg::REG_INSN, insn);
    apb_write(commit_apb_pkg::REG_RS1, rs1);
    apb_write(commit_apb_pkg::REG_RS2, rs2);
    apb_write(commit_apb_pkg::REG_ISSUE, {31'b0, pred});
    n = 0;
    while (!commit_valid && n < 20) begin
      @(negedge CLK);
      n++;
    end
    if (!commit_valid) begin
      errors++;
      $display("commit_valid never rose for insn %h at pc %h", insn, pc);
    end else begin
      check_flag("mal_insn", mal_insn, mal);
      check_flag("illegal_insn", illegal_insn, ill);
      check_flag("update_predictor", update_predictor, is_br);
      if (mal || ill) compare_word("badaddr", badaddr, pc);
      if (is_br) begin
        check_flag("branch_result", branch_result, tkn);
        compare_word("update_addr", update_addr, tgt);
        check_flag("prediction", prediction, pred);
      end
    end
  endtask

`include "branch_commit_tests.svh"

  initial begin
    nRST    = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    halt    = 1'b0;
    repeat (2) @(negedge CLK);  // two cycles in reset
    nRST = 1'b1;
    regs_readback();
    branch_resolution();
    jumps_and_upper();
    misaligned_target();
    illegal_opcode_sticky();
    halt_clears_last_pc();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
logic/rv32_types_pkg.sv
logic/commit_apb_pkg.sv
logic/decode_execute_if.sv
logic/execute_commit_if.sv
logic/apb_issue_regs.sv
logic/insn_decode.sv
logic/branch_execute.sv
logic/commit_stage.sv
logic/branch_commit_top.sv
verif/branch_commit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
TOP        ?= branch_commit_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
